// ==== src/lq_pkg.sv ====
`default_nettype none

package lq_pkg;

    localparam int LQ_DEPTH = 8;
    localparam int LQ_IDX_W = 3;
    localparam int ROB_IDX_W = 5;
    localparam int PADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int BYTE_N = 4;
    localparam int OFFSET_W = 2;
    localparam int COMMIT_W = 2;
    localparam int COMMIT_CNT_W = $clog2(COMMIT_W + 1);

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic                dir;
        logic [LQ_IDX_W-1:0] idx;
    } lq_ptr_t;

    typedef struct packed {
        logic                 dir;
        logic [ROB_IDX_W-1:0] idx;
    } rob_ptr_t;

    typedef struct packed {
        logic     en;
        rob_ptr_t rob;
        reg_idx_t rd;
    } dispatch_t;

    typedef struct packed {
        logic                en;
        logic [LQ_IDX_W-1:0] idx;
        logic [PADDR_W-1:0]  addr;
        logic [1:0]          size;
        logic                uext;
        logic [BYTE_N-1:0]   mask;
        logic                miss;
        logic [BYTE_N-1:0]   fwd_mask;
        logic [DATA_W-1:0]   fwd_data;
    } issue_t;

    typedef struct packed {
        logic                en;
        logic [LQ_IDX_W-1:0] idx;
        logic [DATA_W-1:0]   data;
    } refill_t;

    typedef struct packed {
        rob_ptr_t          rob;
        reg_idx_t          rd;
        logic [DATA_W-1:0] res;
    } wb_t;

    typedef struct packed {
        logic               en;
        lq_ptr_t            lq;
        logic [PADDR_W-1:0] addr;
        logic [BYTE_N-1:0]  mask;
    } store_chk_t;

    typedef struct packed {
        lq_ptr_t  lq;
        rob_ptr_t rob;
    } violation_t;

    typedef struct packed {
        logic     en;
        rob_ptr_t rob;
    } redirect_t;

    // fields read out for the entry being written back
    typedef struct packed {
        rob_ptr_t            rob;
        reg_idx_t            rd;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          size;
        logic                uext;
        logic [BYTE_N-1:0]   fwd_mask;
        logic [DATA_W-1:0]   fwd_data;
        logic [DATA_W-1:0]   data;
    } lq_entry_t;

    // a younger than b, wrap-around age compare
    function automatic logic rob_younger(rob_ptr_t a, rob_ptr_t b);
        return (a.dir ^ b.dir) ^ (a.idx > b.idx);
    endfunction

endpackage

`default_nettype wire

// ==== src/lq_ptr_ctrl.sv ====
`default_nettype none

module lq_ptr_ctrl (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            dispatch_en_i,
    input  wire [lq_pkg::COMMIT_CNT_W-1:0] commit_num_i,
    input  wire                            redirect_en_i,
    input  wire [lq_pkg::LQ_DEPTH-1:0]     younger_i,
    output lq_pkg::lq_ptr_t                head_o,
    output lq_pkg::lq_ptr_t                tail_o,
    output logic                           full_o
);
    import lq_pkg::*;

    logic                redirect_q;
    lq_ptr_t             recover_q;
    logic [LQ_IDX_W:0]   used;
    logic [LQ_IDX_W:0]   keep;
    logic                stop;
    logic [LQ_IDX_W-1:0] pos;

    assign used = tail_o - head_o;

    // survivors run from head up to the first younger entry
    always_comb begin
        keep = '0;
        stop = 1'b0;
        pos = head_o.idx;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            pos = head_o.idx + LQ_IDX_W'(i);
            if (!stop && (i < int'(used)) && !younger_i[pos]) begin
                keep = keep + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_en_i) begin
            recover_q <= lq_ptr_t'(head_o + keep);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_o <= '0;
            tail_o <= '0;
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= redirect_en_i;
            head_o <= lq_ptr_t'(head_o + commit_num_i);
            if (redirect_q) begin
                tail_o <= recover_q;
            end else if (dispatch_en_i && !redirect_en_i) begin
                tail_o <= lq_ptr_t'(tail_o + 1'b1);
            end
        end
    end

    // blocks dispatch until the recovered tail is in place
    assign full_o = ((head_o.idx == tail_o.idx) && (head_o.dir != tail_o.dir)) || redirect_q;

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (!rst)
        dispatch_en_i |-> !full_o)
        else $error("dispatch into a full load queue");

endmodule

`default_nettype wire

// ==== src/lq_entry_array.sv ====
`default_nettype none

module lq_entry_array (
    input  wire                            clk,
    input  wire                            rst,
    input  wire lq_pkg::dispatch_t         dispatch_i,
    input  wire lq_pkg::lq_ptr_t           tail_i,
    input  wire lq_pkg::issue_t            issue_i,
    input  wire lq_pkg::refill_t           refill_i,
    input  wire [lq_pkg::COMMIT_CNT_W-1:0] commit_num_i,
    input  wire lq_pkg::lq_ptr_t           head_i,
    input  wire lq_pkg::redirect_t         redirect_i,
    input  wire                            wb_done_i,
    input  wire [lq_pkg::LQ_IDX_W-1:0]     wb_idx_i,
    output logic [lq_pkg::LQ_DEPTH-1:0]    valid_o,
    output logic [lq_pkg::LQ_DEPTH-1:0]    addr_valid_o,
    output logic [lq_pkg::LQ_DEPTH-1:0]    younger_o,
    output logic [lq_pkg::LQ_DEPTH-1:0]    waiting_o,
    output lq_pkg::lq_entry_t              rd_entry_o,
    output lq_pkg::rob_ptr_t               rob_o [lq_pkg::LQ_DEPTH],
    output logic [lq_pkg::PADDR_W-1:0]     addr_o [lq_pkg::LQ_DEPTH],
    output logic [lq_pkg::BYTE_N-1:0]      mask_o [lq_pkg::LQ_DEPTH]
);
    import lq_pkg::*;

    logic [LQ_DEPTH-1:0] miss_q, data_valid_q, written_q;
    logic [LQ_DEPTH-1:0] commit_clr;
    logic [LQ_DEPTH-1:0] uext_q;
    logic                dispatch_go;
    reg_idx_t            rd_q [LQ_DEPTH];
    logic [1:0]          size_q [LQ_DEPTH];
    logic [BYTE_N-1:0]   fwd_mask_q [LQ_DEPTH];
    logic [DATA_W-1:0]   fwd_data_q [LQ_DEPTH];
    logic [DATA_W-1:0]   data_q [LQ_DEPTH];

    // loads dispatched alongside a redirect are on the wrong path
    assign dispatch_go = dispatch_i.en && !redirect_i.en;

    always_comb begin
        commit_clr = '0;
        for (int j = 0; j < COMMIT_W; j++) begin
            if (j < int'(commit_num_i)) begin
                commit_clr[head_i.idx + LQ_IDX_W'(j)] = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_age
        assign younger_o[i] = valid_o[i] && rob_younger(rob_o[i], redirect_i.rob);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_o <= '0;
            addr_valid_o <= '0;
            miss_q <= '0;
            data_valid_q <= '0;
            written_q <= '0;
        end else begin
            valid_o <= (valid_o & ~(younger_o & {LQ_DEPTH{redirect_i.en}}) & ~commit_clr);
            if (dispatch_go) begin
                valid_o[tail_i.idx] <= 1'b1;
                addr_valid_o[tail_i.idx] <= 1'b0;
                miss_q[tail_i.idx] <= 1'b0;
                data_valid_q[tail_i.idx] <= 1'b0;
                written_q[tail_i.idx] <= 1'b0;
            end
            if (issue_i.en) begin
                addr_valid_o[issue_i.idx] <= 1'b1;
                miss_q[issue_i.idx] <= issue_i.miss;
                data_valid_q[issue_i.idx] <= !issue_i.miss;
            end
            if (refill_i.en) begin
                data_valid_q[refill_i.idx] <= 1'b1;
            end
            if (wb_done_i) begin
                written_q[wb_idx_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_go) begin
            rob_o[tail_i.idx] <= dispatch_i.rob;
            rd_q[tail_i.idx] <= dispatch_i.rd;
        end
        if (issue_i.en) begin
            addr_o[issue_i.idx] <= issue_i.addr;
            mask_o[issue_i.idx] <= issue_i.mask;
            size_q[issue_i.idx] <= issue_i.size;
            uext_q[issue_i.idx] <= issue_i.uext;
            fwd_mask_q[issue_i.idx] <= issue_i.fwd_mask;
            fwd_data_q[issue_i.idx] <= issue_i.fwd_data;
        end
        if (refill_i.en) begin
            data_q[refill_i.idx] <= refill_i.data;
        end
    end

    assign waiting_o = valid_o & miss_q & data_valid_q & ~written_q;

    assign rd_entry_o.rob = rob_o[wb_idx_i];
    assign rd_entry_o.rd = rd_q[wb_idx_i];
    assign rd_entry_o.offset = addr_o[wb_idx_i][OFFSET_W-1:0];
    assign rd_entry_o.size = size_q[wb_idx_i];
    assign rd_entry_o.uext = uext_q[wb_idx_i];
    assign rd_entry_o.fwd_mask = fwd_mask_q[wb_idx_i];
    assign rd_entry_o.fwd_data = fwd_data_q[wb_idx_i];
    assign rd_entry_o.data = data_q[wb_idx_i];

    a_refill_target: assert property (@(posedge clk) disable iff (!rst)
        refill_i.en |-> valid_o[refill_i.idx] && miss_q[refill_i.idx])
        else $error("refill for an entry that is not a pending miss");

endmodule

`default_nettype wire

// ==== src/lq_writeback.sv ====
`default_nettype none

module lq_writeback (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [lq_pkg::LQ_DEPTH-1:0] waiting_i,
    input  wire                        redirect_en_i,
    input  wire lq_pkg::lq_entry_t     rd_entry_i,
    input  wire                        wb_ready_i,
    output logic [lq_pkg::LQ_IDX_W-1:0] wb_idx_o,
    output logic                       wb_done_o,
    output logic                       wb_valid_o,
    output lq_pkg::wb_t                wb_o
);
    import lq_pkg::*;

    logic [LQ_IDX_W-1:0] sel_idx, idx_q;
    logic                valid_q, redirect_q, load;
    logic [DATA_W-1:0]   merged, shifted, res;

    // lowest waiting index wins
    always_comb begin
        sel_idx = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (waiting_i[i]) begin
                sel_idx = LQ_IDX_W'(i);
            end
        end
    end

    assign load = !valid_q && (|waiting_i) && !redirect_en_i && !redirect_q;
    assign wb_idx_o = valid_q ? idx_q : sel_idx;
    assign wb_valid_o = valid_q && !redirect_en_i;
    assign wb_done_o = wb_valid_o && wb_ready_i;

    always_comb begin
        for (int b = 0; b < BYTE_N; b++) begin
            merged[b*8 +: 8] = rd_entry_i.fwd_mask[b] ? rd_entry_i.fwd_data[b*8 +: 8]
                                                      : rd_entry_i.data[b*8 +: 8];
        end
        shifted = merged >> {rd_entry_i.offset, 3'b000};
        case (rd_entry_i.size)
            2'd0: res = {{(DATA_W - 8){!rd_entry_i.uext && shifted[7]}}, shifted[7:0]};
            2'd1: res = {{(DATA_W - 16){!rd_entry_i.uext && shifted[15]}}, shifted[15:0]};
            default: res = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= redirect_en_i;
            // a cancelled entry stays waiting and is picked again if it survives
            if (redirect_en_i || wb_done_o) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            idx_q <= sel_idx;
            wb_o.rob <= rd_entry_i.rob;
            wb_o.rd <= rd_entry_i.rd;
            wb_o.res <= res;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
        wb_valid_o && !wb_ready_i |=> $stable(wb_o))
        else $error("writeback data changed while stalled");

endmodule

`default_nettype wire

// ==== src/lq_violation_check.sv ====
`default_nettype none

module lq_violation_check (
    input  wire                         clk,
    input  wire                         rst,
    input  wire lq_pkg::store_chk_t     store_i,
    input  wire lq_pkg::lq_ptr_t        head_i,
    input  wire [lq_pkg::LQ_DEPTH-1:0]  valid_i,
    input  wire [lq_pkg::LQ_DEPTH-1:0]  addr_valid_i,
    input  wire [lq_pkg::PADDR_W-1:0]   addr_i [lq_pkg::LQ_DEPTH],
    input  wire [lq_pkg::BYTE_N-1:0]    mask_i [lq_pkg::LQ_DEPTH],
    input  wire lq_pkg::rob_ptr_t       rob_i [lq_pkg::LQ_DEPTH],
    input  wire [lq_pkg::LQ_DEPTH-1:0]  younger_i,
    input  wire                         redirect_en_i,
    output logic                        viol_valid_o,
    output lq_pkg::violation_t          viol_o
);
    import lq_pkg::*;

    logic [LQ_IDX_W:0]   store_rel;
    logic [LQ_DEPTH-1:0] age_mask;
    logic [LQ_DEPTH-1:0] match;
    logic                found;
    logic [LQ_IDX_W-1:0] oldest;

    // store position counted from head; beyond the depth means behind head
    assign store_rel = store_i.lq - head_i;

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_match
        logic [LQ_IDX_W:0] rel;

        assign rel = {1'b0, LQ_IDX_W'(i) - head_i.idx};
        assign age_mask[i] = (int'(store_rel) > LQ_DEPTH) || (store_rel <= rel);
        assign match[i] = store_i.en && valid_i[i] && addr_valid_i[i] && age_mask[i]
                          && (addr_i[i][PADDR_W-1:OFFSET_W] == store_i.addr[PADDR_W-1:OFFSET_W])
                          && (|(mask_i[i] & store_i.mask))
                          && !(redirect_en_i && younger_i[i]);
    end

    // oldest by rob position
    always_comb begin
        found = 1'b0;
        oldest = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (match[i] && (!found || rob_younger(rob_i[oldest], rob_i[i]))) begin
                found = 1'b1;
                oldest = LQ_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            viol_valid_o <= 1'b0;
        end else begin
            viol_valid_o <= found;
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            viol_o.lq.idx <= oldest;
            // slots below head are on the next lap
            viol_o.lq.dir <= (oldest < head_i.idx) ? !head_i.dir : head_i.dir;
            viol_o.rob <= rob_i[oldest];
        end
    end

endmodule

`default_nettype wire

// ==== src/lq_top.sv ====
`default_nettype none

module lq_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire lq_pkg::dispatch_t         dispatch_i,
    output lq_pkg::lq_ptr_t                alloc_o,
    output logic                           full_o,
    input  wire lq_pkg::issue_t            issue_i,
    input  wire lq_pkg::refill_t           refill_i,
    input  wire [lq_pkg::COMMIT_CNT_W-1:0] commit_num_i,
    input  wire lq_pkg::redirect_t         redirect_i,
    input  wire lq_pkg::store_chk_t        store_i,
    output logic                           wb_valid_o,
    input  wire                            wb_ready_i,
    output lq_pkg::wb_t                    wb_o,
    output logic                           viol_valid_o,
    output lq_pkg::violation_t             viol_o
);
    import lq_pkg::*;

    lq_ptr_t             head;
    logic [LQ_DEPTH-1:0] valid;
    logic [LQ_DEPTH-1:0] addr_valid;
    logic [LQ_DEPTH-1:0] younger;
    logic [LQ_DEPTH-1:0] waiting;
    lq_entry_t           rd_entry;
    rob_ptr_t            rob [LQ_DEPTH];
    logic [PADDR_W-1:0]  addr [LQ_DEPTH];
    logic [BYTE_N-1:0]   mask [LQ_DEPTH];
    logic                wb_done;
    logic [LQ_IDX_W-1:0] wb_idx;

    lq_ptr_ctrl ptr_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .dispatch_en_i (dispatch_i.en),
        .commit_num_i  (commit_num_i),
        .redirect_en_i (redirect_i.en),
        .younger_i     (younger),
        .head_o        (head),
        .tail_o        (alloc_o),
        .full_o        (full_o)
    );

    lq_entry_array entry_array_i (
        .clk          (clk),
        .rst          (rst),
        .dispatch_i   (dispatch_i),
        .tail_i       (alloc_o),
        .issue_i      (issue_i),
        .refill_i     (refill_i),
        .commit_num_i (commit_num_i),
        .head_i       (head),
        .redirect_i   (redirect_i),
        .wb_done_i    (wb_done),
        .wb_idx_i     (wb_idx),
        .valid_o      (valid),
        .addr_valid_o (addr_valid),
        .younger_o    (younger),
        .waiting_o    (waiting),
        .rd_entry_o   (rd_entry),
        .rob_o        (rob),
        .addr_o       (addr),
        .mask_o       (mask)
    );

    lq_writeback writeback_i (
        .clk           (clk),
        .rst           (rst),
        .waiting_i     (waiting),
        .redirect_en_i (redirect_i.en),
        .rd_entry_i    (rd_entry),
        .wb_ready_i    (wb_ready_i),
        .wb_idx_o      (wb_idx),
        .wb_done_o     (wb_done),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    lq_violation_check violation_check_i (
        .clk           (clk),
        .rst           (rst),
        .store_i       (store_i),
        .head_i        (head),
        .valid_i       (valid),
        .addr_valid_i  (addr_valid),
        .addr_i        (addr),
        .mask_i        (mask),
        .rob_i         (rob),
        .younger_i     (younger),
        .redirect_en_i (redirect_i.en),
        .viol_valid_o  (viol_valid_o),
        .viol_o        (viol_o)
    );

endmodule

`default_nettype wire

// ==== testbench/lq_tb_model.svh ====
// a younger than b by wrap-around order
function automatic logic model_younger(lq_pkg::rob_ptr_t a, lq_pkg::rob_ptr_t b);
    if (a.dir == b.dir) begin
        return a.idx > b.idx;
    end
    return a.idx < b.idx;
endfunction

function automatic logic [31:0] load_result(logic [31:0] data, logic [3:0] fwd_mask,
                                            logic [31:0] fwd_data, logic [1:0] offset,
                                            logic [1:0] size, logic uext);
    logic [31:0] word;
    logic [7:0]  bytes [4];
    for (int b = 0; b < 4; b++) begin
        bytes[b] = fwd_mask[b] ? fwd_data[8*b +: 8] : data[8*b +: 8];
    end
    word = '0;
    for (int b = 0; b < 4; b++) begin
        if (b + offset < 4) begin
            word[8*b +: 8] = bytes[b + offset];
        end
    end
    if (size == 2'd0) begin
        return uext ? {24'd0, word[7:0]} : {{24{word[7]}}, word[7:0]};
    end
    if (size == 2'd1) begin
        return uext ? {16'd0, word[15:0]} : {{16{word[15]}}, word[15:0]};
    end
    return word;
endfunction

// queue slot of the oldest issued load hit by the store, or -1
function automatic int oldest_violation(lq_pkg::store_chk_t st);
    int start;
    int idx;
    start = (st.lq - tb_head) & 4'hf;
    for (int k = 0; k < 8; k++) begin
        idx = (tb_head.idx + k) % 8;
        if (k >= start && tb_valid[idx] && tb_issued[idx]
            && tb_addr[idx][15:2] == st.addr[15:2] && (tb_mask[idx] & st.mask) != 0) begin
            return idx;
        end
    end
    return -1;
endfunction

function automatic lq_pkg::lq_ptr_t recovered_tail(lq_pkg::rob_ptr_t rob);
    int keep;
    int idx;
    keep = 0;
    for (int k = 0; k < 8; k++) begin
        idx = (tb_head.idx + k) % 8;
        if (!tb_valid[idx] || model_younger(tb_rob[idx], rob)) begin
            break;
        end
        keep++;
    end
    return lq_pkg::lq_ptr_t'(tb_head + keep);
endfunction

// ==== testbench/lq_tb.sv ====
`default_nettype none

module lq_tb;
    import lq_pkg::*;

    logic                    clk;
    logic                    rst;
    dispatch_t               dispatch;
    lq_ptr_t                 alloc;
    logic                    full;
    issue_t                  issue;
    refill_t                 refill;
    logic [COMMIT_CNT_W-1:0] commit_num;
    redirect_t               redirect;
    store_chk_t              store;
    logic                    wb_valid;
    logic                    wb_ready;
    wb_t                     wb;
    logic                    viol_valid;
    violation_t              viol;

    // model view of the queue
    lq_ptr_t     tb_head;
    lq_ptr_t     tb_tail;
    logic        tb_valid [8];
    logic        tb_issued [8];
    rob_ptr_t    tb_rob [8];
    reg_idx_t    tb_rd [8];
    logic [15:0] tb_addr [8];
    logic [3:0]  tb_mask [8];
    logic [1:0]  tb_size [8];
    logic        tb_uext [8];
    logic [3:0]  tb_fwd_mask [8];
    logic [31:0] tb_fwd_data [8];
    logic        exp_pending [64];
    logic [31:0] exp_res [64];
    reg_idx_t    exp_rd [64];
    int          wb_count;
    int          order_q [$];
    logic [15:0] lfsr;
    logic        prev_stall;
    wb_t         prev_wb;

    `include "lq_tb_model.svh"

    lq_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .dispatch_i   (dispatch),
        .alloc_o      (alloc),
        .full_o       (full),
        .issue_i      (issue),
        .refill_i     (refill),
        .commit_num_i (commit_num),
        .redirect_i   (redirect),
        .store_i      (store),
        .wb_valid_o   (wb_valid),
        .wb_ready_i   (wb_ready),
        .wb_o         (wb),
        .viol_valid_o (viol_valid),
        .viol_o       (viol)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_equal(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch_load(int rob_idx);
        check_equal("alloc_o", alloc, tb_tail);
        check_equal("full_o before dispatch", full, 0);
        tb_valid[tb_tail.idx] = 1'b1;
        tb_issued[tb_tail.idx] = 1'b0;
        tb_rob[tb_tail.idx] = rob_ptr_t'(rob_idx);
        tb_rd[tb_tail.idx] = reg_idx_t'(rob_idx + 1);
        dispatch = '{en: 1'b1, rob: rob_ptr_t'(rob_idx), rd: reg_idx_t'(rob_idx + 1)};
        step();
        dispatch.en = 1'b0;
        tb_tail = lq_ptr_t'(tb_tail + 1);
    endtask

    task automatic issue_load(int idx, logic force_word, logic [13:0] word);
        tb_addr[idx] = force_word ? {word, 2'(rand_bits(2))} : 16'(rand_bits(16));
        tb_size[idx] = 2'(rand_bits(2) % 3);
        tb_uext[idx] = 1'(rand_bits(1));
        tb_mask[idx] = 4'(rand_bits(4)) | 4'b0001;
        tb_fwd_mask[idx] = 4'(rand_bits(4));
        tb_fwd_data[idx] = rand_bits(32);
        tb_issued[idx] = 1'b1;
        issue = '{en: 1'b1, idx: 3'(idx), addr: tb_addr[idx], size: tb_size[idx],
                  uext: tb_uext[idx], mask: tb_mask[idx], miss: 1'b1,
                  fwd_mask: tb_fwd_mask[idx], fwd_data: tb_fwd_data[idx]};
        step();
        issue.en = 1'b0;
    endtask

    task automatic refill_load(int idx);
        logic [31:0] data;
        data = rand_bits(32);
        exp_res[tb_rob[idx]] = load_result(data, tb_fwd_mask[idx], tb_fwd_data[idx],
                                           tb_addr[idx][1:0], tb_size[idx], tb_uext[idx]);
        exp_rd[tb_rob[idx]] = tb_rd[idx];
        exp_pending[tb_rob[idx]] = 1'b1;
        refill = '{en: 1'b1, idx: 3'(idx), data: data};
        step();
        refill.en = 1'b0;
    endtask

    task automatic store_check(lq_ptr_t lq, logic [13:0] word, logic [3:0] mask);
        int exp;
        store = '{en: 1'b1, lq: lq, addr: {word, 2'b00}, mask: mask};
        exp = oldest_violation(store);
        step();
        store.en = 1'b0;
        check_equal("viol_valid_o", viol_valid, exp >= 0);
        if (exp >= 0) begin
            check_equal("viol_o.lq", viol.lq, lq_ptr_t'(tb_head + ((exp - tb_head.idx) & 7)));
            check_equal("viol_o.rob", viol.rob, tb_rob[exp]);
        end
        step();
        check_equal("viol_valid_o pulse", viol_valid, 0);
    endtask

    task automatic drain_writebacks(int target);
        int t;
        t = 0;
        while (wb_count < target) begin
            wb_ready = 1'(rand_bits(1));
            step();
            t++;
            if (t > 1000) begin
                $display("timed out waiting for load writebacks");
                $display("*** TEST FAILED ***");
                $fatal(1);
            end
        end
        wb_ready = 1'b0;
    endtask

    // writeback scoreboard and stall hold check
    always @(posedge clk) begin
        if (rst) begin
            if (prev_stall) begin
                check_equal("wb_o held while stalled", wb, prev_wb);
            end
            if (wb_valid && wb_ready) begin
                check_equal("writeback expected for rob", exp_pending[wb.rob], 1);
                check_equal("wb_o.res", wb.res, exp_res[wb.rob]);
                check_equal("wb_o.rd", wb.rd, exp_rd[wb.rob]);
                if (order_q.size() > 0) begin
                    check_equal("writeback order", wb.rob.idx, order_q.pop_front());
                end
                exp_pending[wb.rob] = 1'b0;
                wb_count++;
            end
            prev_stall = wb_valid && !wb_ready;
            prev_wb = wb;
        end
    end

    initial begin
        lfsr = 16'd38272;
        rst = 1'b0;
        dispatch = '0;
        issue = '0;
        refill = '0;
        commit_num = '0;
        redirect = '0;
        store = '0;
        wb_ready = 1'b0;
        tb_head = '0;
        tb_tail = '0;
        wb_count = 0;
        prev_stall = 1'b0;
        prev_wb = '0;
        for (int i = 0; i < 8; i++) begin
            tb_valid[i] = 1'b0;
            tb_issued[i] = 1'b0;
        end
        for (int i = 0; i < 64; i++) begin
            exp_pending[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        step();
        check_equal("full_o after reset", full, 0);
        check_equal("viol_valid_o after reset", viol_valid, 0);
        check_equal("wb_valid_o after reset", wb_valid, 0);

        for (int i = 0; i < 8; i++) begin
            dispatch_load(i);
        end
        check_equal("full_o after eight", full, 1);

        // loads 1, 3, 5 and 6 share one word
        for (int i = 0; i < 7; i++) begin
            issue_load(i, i == 1 || i == 3 || i == 5 || i == 6, 14'h0123);
        end
        store_check('{dir: 1'b0, idx: 3'd3}, 14'h0123, 4'b0001);
        store_check('{dir: 1'b0, idx: 3'd7}, 14'h0123, 4'b1111);
        store_check('{dir: 1'b0, idx: 3'd0}, 14'h0123, 4'b0000);
        issue_load(7, 1'b0, 14'h0);

        // entry 7 is captured first, the rest follow from the lowest index
        refill_load(7);
        order_q.push_back(7);
        for (int i = 0; i < 7; i++) begin
            refill_load(i);
            order_q.push_back(i);
        end
        drain_writebacks(8);

        commit_num = 2'd2;
        step();
        commit_num = 2'd1;
        step();
        commit_num = 2'd0;
        for (int i = 0; i < 3; i++) begin
            tb_valid[i] = 1'b0;
        end
        tb_head = lq_ptr_t'(3);
        check_equal("full_o after commit", full, 0);
        for (int i = 8; i < 11; i++) begin
            dispatch_load(i);
        end
        check_equal("full_o after wrap", full, 1);
        for (int i = 0; i < 3; i++) begin
            issue_load(i, 1'b0, 14'h0);
            refill_load(i);
        end

        begin
            lq_ptr_t exp_tail;
            exp_tail = recovered_tail(rob_ptr_t'(8));
            for (int i = 0; i < 8; i++) begin
                if (tb_valid[i] && model_younger(tb_rob[i], rob_ptr_t'(8))) begin
                    tb_valid[i] = 1'b0;
                    exp_pending[tb_rob[i]] = 1'b0;
                end
            end
            redirect = '{en: 1'b1, rob: rob_ptr_t'(8)};
            step();
            redirect.en = 1'b0;
            check_equal("full_o after redirect", full, 1);
            step();
            check_equal("recovered tail", alloc, exp_tail);
            tb_tail = exp_tail;
        end
        drain_writebacks(9);
        wb_ready = 1'b1;
        repeat (20) step();
        check_equal("writeback count", wb_count, 9);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+testbench
src/lq_pkg.sv
src/lq_ptr_ctrl.sv
src/lq_entry_array.sv
src/lq_writeback.sv
src/lq_violation_check.sv
src/lq_top.sv
testbench/lq_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lq_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
